// ==== Makefile ====
# Verilator build and run of the execute control unit testbench

TOP := ecl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bypass/ecl_issue_bypass.sv ====
`default_nettype none
`include "ecl_settings.svh"

module ecl_issue_bypass (
   input  ecl_pkg::issue_e_t issue,
   input  ecl_pkg::wb_t      fwd_m,
   input  ecl_pkg::wb_t      wb,
   output ecl_pkg::alu_req_t alu_req,
   output ecl_pkg::lsu_req_t lsu_req,
   output ecl_pkg::bru_req_t bru_req,
   output ecl_pkg::mul_req_t mul_req
);

   import ecl_pkg::*;

   fwd_sel_e              rs1_sel;
   fwd_sel_e              rs2_sel;
   fwd_sel_e              off_sel;
   logic [`ECL_GRLEN-1:0] rs1_val;
   logic [`ECL_GRLEN-1:0] rs2_val;
   logic [`ECL_GRLEN-1:0] off_val;
   logic [`ECL_GRLEN-1:0] lsu_offset;

   // youngest producer wins, m before w
   function automatic fwd_sel_e pick_src(
      input logic [`ECL_RADDR_W-1:0] rs,
      input logic                    keep_rf,
      input wb_t                     m,
      input wb_t                     w
   );
      fwd_sel_e sel;
      if (keep_rf) begin
         sel = fwd_rf;
      end else if (m.wen && (m.rd == rs)) begin
         sel = ecl_pkg::fwd_m;
      end else if (w.wen && (w.rd == rs)) begin
         sel = fwd_w;
      end else begin
         sel = fwd_rf;
      end
      return sel;
   endfunction

   function automatic logic [`ECL_GRLEN-1:0] pick_data(
      input fwd_sel_e              sel,
      input logic [`ECL_GRLEN-1:0] rf_val,
      input logic [`ECL_GRLEN-1:0] m_val,
      input logic [`ECL_GRLEN-1:0] w_val
   );
      logic [`ECL_GRLEN-1:0] val;
      case (sel)
         ecl_pkg::fwd_m: val = m_val;
         fwd_w:          val = w_val;
         default:        val = rf_val;
      endcase
      return val;
   endfunction

   // pc in a, imm in b are never replaced
   assign rs1_sel = pick_src(issue.rs1, issue.pc_a, fwd_m, wb);
   assign rs2_sel = pick_src(issue.rs2, issue.imm_b | issue.double_read, fwd_m, wb);
   assign off_sel = pick_src(issue.rs2, 1'b0, fwd_m, wb);

   assign rs1_val = pick_data(rs1_sel, issue.a_d, fwd_m.data, wb.data);
   assign rs2_val = pick_data(rs2_sel, issue.b_d, fwd_m.data, wb.data);
   assign off_val = pick_data(off_sel, issue.b_d, fwd_m.data, wb.data);

   // indexed address takes rk, else the immediate
   assign lsu_offset = issue.double_read ? off_val : issue.imm;

   assign alu_req = '{a: rs1_val, b: rs2_val, op: issue.alu_op, c: issue.c,
                      double_word: issue.double_word};

   assign lsu_req = '{valid: issue.lsu_valid, op: issue.lsu_op, base: rs1_val,
                      offset: lsu_offset, wdata: rs2_val, rd: issue.rf_target,
                      wen: issue.lsu_wen};

   assign bru_req = '{valid: issue.bru_valid, op: issue.bru_op, a: rs1_val, b: rs2_val,
                      pc: issue.pc, offset: issue.br_offs};

   assign mul_req = '{valid: issue.mul_valid, a: rs1_val, b: rs2_val,
                      signed_op: issue.mul_signed, double_op: issue.mul_double,
                      hi: issue.mul_hi, short_op: issue.mul_short};

endmodule

`default_nettype wire

// ==== common/ecl_pkg.sv ====
`default_nettype none
`include "ecl_settings.svh"

package ecl_pkg;

   typedef enum logic [2:0] {unit_alu, unit_lsu, unit_bru, unit_mul, unit_none} unit_e;

   typedef enum logic [2:0] {
      mul_w, mulh_w, mulh_wu, mul_d, mulh_d, mulh_du, mulw_d_w, mulw_d_wu
   } mul_op_e;

   // operand source in the e stage
   typedef enum logic [1:0] {fwd_rf, fwd_m, fwd_w} fwd_sel_e;

   typedef struct packed {
      unit_e                        unit;
      logic [`ECL_ALU_CODE_W-1:0]   alu_code;
      logic [`ECL_LSU_CODE_W-1:0]   lsu_code;
      logic [`ECL_BRU_CODE_W-1:0]   bru_code;
      mul_op_e                      mul_op;
      logic                         rd_to_rj, rd_read, imm_b, pc_a;
      logic                         double_read, double_word;
   } dec_op_t;

   typedef struct packed {
      logic                         valid;
      logic [31:0]                  inst;
      logic [`ECL_GRLEN-1:0]        pc;
      dec_op_t                      op;
      logic                         rf_wen;
      logic [`ECL_RADDR_W-1:0]      rf_target;
      logic [`ECL_GRLEN-1:0]        imm, c, br_offs;
   } dec_in_t;

   // d-to-e pipeline state
   typedef struct packed {
      logic                         alu_valid, lsu_valid, bru_valid, mul_valid;
      logic [`ECL_ALU_CODE_W-1:0]   alu_op;
      logic [`ECL_LSU_CODE_W-1:0]   lsu_op;
      logic [`ECL_BRU_CODE_W-1:0]   bru_op;
      logic                         double_word;
      logic                         mul_signed, mul_double, mul_hi, mul_short;
      logic [`ECL_GRLEN-1:0]        a_d, b_d, imm, pc, br_offs, c;
      logic [`ECL_RADDR_W-1:0]      rs1, rs2;
      logic                         pc_a, imm_b, double_read;
      logic [`ECL_RADDR_W-1:0]      rf_target;
      logic                         alu_wen, mul_wen, lsu_wen;
   } issue_e_t;

   typedef struct packed {
      logic [`ECL_GRLEN-1:0]        a, b;
      logic [`ECL_ALU_CODE_W-1:0]   op;
      logic [`ECL_GRLEN-1:0]        c;
      logic                         double_word;
   } alu_req_t;

   typedef struct packed {
      logic                         valid;
      logic [`ECL_LSU_CODE_W-1:0]   op;
      logic [`ECL_GRLEN-1:0]        base, offset, wdata;
      logic [`ECL_RADDR_W-1:0]      rd;
      logic                         wen;
   } lsu_req_t;

   typedef struct packed {
      logic                         valid;
      logic [`ECL_BRU_CODE_W-1:0]   op;
      logic [`ECL_GRLEN-1:0]        a, b, pc, offset;
   } bru_req_t;

   typedef struct packed {
      logic [`ECL_GRLEN-1:0]        brpc;
      logic                         taken;
      logic [`ECL_GRLEN-1:0]        link_pc;
      logic                         wen;
   } bru_resp_t;

   typedef struct packed {
      logic                         valid;
      logic [`ECL_GRLEN-1:0]        a, b;
      logic                         signed_op, double_op, hi, short_op;
   } mul_req_t;

   typedef struct packed {
      logic [`ECL_GRLEN-1:0]        rdata;
      logic                         rdata_valid;
      logic [`ECL_RADDR_W-1:0]      rd;
      logic                         wen;
   } lsu_resp_t;

   // register write, m-stage forward and w-stage port
   typedef struct packed {
      logic [`ECL_GRLEN-1:0]        data;
      logic                         wen;
      logic [`ECL_RADDR_W-1:0]      rd;
   } wb_t;

endpackage

`default_nettype wire

// ==== common/ecl_settings.svh ====
`ifndef ECL_SETTINGS_SVH
`define ECL_SETTINGS_SVH

// general register width
`define ECL_GRLEN        64
`define ECL_RADDR_W      5

// unit opcode field widths
`define ECL_ALU_CODE_W   6
`define ECL_LSU_CODE_W   8
`define ECL_BRU_CODE_W   4

// register fields inside the instruction word
`define ECL_RD_LSB       0
`define ECL_RJ_LSB       5
`define ECL_RK_LSB       10

`endif

// ==== dispatch/ecl_dispatch.sv ====
`default_nettype none
`include "ecl_settings.svh"

module ecl_dispatch (
   input  logic                    clk,
   input  logic                    reset,
   input  ecl_pkg::dec_in_t        dec,
   input  logic [`ECL_GRLEN-1:0]   rs1_data_d,
   input  logic [`ECL_GRLEN-1:0]   rs2_data_d,
   input  logic                    bru_taken_e,
   input  logic                    lsu_rdata_valid_m,
   output logic [`ECL_RADDR_W-1:0] rs1_addr_d,
   output logic [`ECL_RADDR_W-1:0] rs2_addr_d,
   output ecl_pkg::issue_e_t       issue,
   output logic                    br_taken,
   output logic                    stall_req
);

   import ecl_pkg::*;

   logic                    inst_vld_d;
   logic                    is_alu_d;
   logic                    is_lsu_d;
   logic                    is_mul_d;
   logic                    alu_disp_d;
   logic                    lsu_disp_d;
   logic                    bru_disp_d;
   logic                    mul_disp_d;
   logic [`ECL_RADDR_W-1:0] rd_d;
   logic [`ECL_RADDR_W-1:0] rj_d;
   logic [`ECL_RADDR_W-1:0] rk_d;
   logic                    imm_b_d;
   logic                    double_read_d;
   logic [`ECL_GRLEN-1:0]   a_d;
   logic [`ECL_GRLEN-1:0]   b_d;
   logic                    mul_signed_d;
   logic                    mul_double_d;
   logic                    mul_hi_d;
   logic                    mul_short_d;
   logic                    load_pend;

   // taken branch in e drops the instruction now in d
   assign br_taken   = issue.bru_valid & bru_taken_e;
   assign inst_vld_d = dec.valid & ~br_taken;

   assign is_alu_d = (dec.op.unit == unit_alu);
   assign is_lsu_d = (dec.op.unit == unit_lsu);
   assign is_mul_d = (dec.op.unit == unit_mul);

   // unit_none retires here, no strobe
   assign alu_disp_d = inst_vld_d & is_alu_d;
   assign lsu_disp_d = inst_vld_d & is_lsu_d;
   assign bru_disp_d = inst_vld_d & (dec.op.unit == unit_bru);
   assign mul_disp_d = inst_vld_d & is_mul_d;

   // register read ports
   assign rd_d = dec.inst[`ECL_RD_LSB +: `ECL_RADDR_W];
   assign rj_d = dec.inst[`ECL_RJ_LSB +: `ECL_RADDR_W];
   assign rk_d = dec.inst[`ECL_RK_LSB +: `ECL_RADDR_W];

   assign rs1_addr_d = dec.op.rd_to_rj ? rd_d : rj_d;
   assign rs2_addr_d = dec.op.rd_read ? rd_d : rk_d;

   // immediate b only for alu ops, indexed offset only for loads/stores
   assign imm_b_d       = dec.op.imm_b & is_alu_d;
   assign double_read_d = dec.op.double_read & is_lsu_d;

   assign a_d = dec.op.pc_a ? dec.pc : rs1_data_d;
   assign b_d = imm_b_d ? dec.imm : rs2_data_d;

   // multiplier flag table
   always_comb begin
      mul_signed_d = 1'b0;
      mul_double_d = 1'b0;
      mul_hi_d     = 1'b0;
      mul_short_d  = 1'b0;
      unique case (dec.op.mul_op)
         mul_w: begin
            mul_signed_d = 1'b1;
            mul_short_d  = 1'b1;
         end
         mulh_w: begin
            mul_signed_d = 1'b1;
            mul_hi_d     = 1'b1;
            mul_short_d  = 1'b1;
         end
         mulh_wu: begin
            mul_hi_d     = 1'b1;
            mul_short_d  = 1'b1;
         end
         mul_d: begin
            mul_signed_d = 1'b1;
            mul_double_d = 1'b1;
         end
         mulh_d: begin
            mul_signed_d = 1'b1;
            mul_double_d = 1'b1;
            mul_hi_d     = 1'b1;
         end
         mulh_du: begin
            mul_double_d = 1'b1;
            mul_hi_d     = 1'b1;
         end
         mulw_d_w: begin
            mul_signed_d = 1'b1;
         end
         mulw_d_wu: begin
            mul_signed_d = 1'b0;
         end
      endcase
   end

   // d to e
   always_ff @(posedge clk) begin
      if (reset) begin
         issue.alu_valid <= 1'b0;
         issue.lsu_valid <= 1'b0;
         issue.bru_valid <= 1'b0;
         issue.mul_valid <= 1'b0;
      end else begin
         issue.alu_valid <= alu_disp_d;
         issue.lsu_valid <= lsu_disp_d;
         issue.bru_valid <= bru_disp_d;
         issue.mul_valid <= mul_disp_d;
      end
      issue.alu_op      <= dec.op.alu_code;
      issue.lsu_op      <= dec.op.lsu_code;
      issue.bru_op      <= dec.op.bru_code;
      issue.double_word <= dec.op.double_word;
      issue.mul_signed  <= mul_signed_d;
      issue.mul_double  <= mul_double_d;
      issue.mul_hi      <= mul_hi_d;
      issue.mul_short   <= mul_short_d;
      issue.a_d         <= a_d;
      issue.b_d         <= b_d;
      issue.imm         <= dec.imm;
      issue.pc          <= dec.pc;
      issue.br_offs     <= dec.br_offs;
      issue.c           <= dec.c;
      issue.rs1         <= rs1_addr_d;
      issue.rs2         <= rs2_addr_d;
      issue.pc_a        <= dec.op.pc_a;
      issue.imm_b       <= imm_b_d;
      issue.double_read <= double_read_d;
      issue.rf_target   <= dec.rf_target;
      issue.alu_wen     <= dec.rf_wen & is_alu_d;
      issue.mul_wen     <= dec.rf_wen & is_mul_d;
      issue.lsu_wen     <= dec.rf_wen & is_lsu_d;
   end

   // outstanding load, set on dispatch, cleared once data returns
   always_ff @(posedge clk) begin
      if (reset) begin
         load_pend <= 1'b0;
      end else begin
         load_pend <= lsu_disp_d | (load_pend & ~lsu_rdata_valid_m);
      end
   end

   assign stall_req = lsu_disp_d | load_pend;

   // upstream must hold off while the load is in flight
   a_no_lsu_while_pending: assert property (
      @(posedge clk) disable iff (reset) load_pend |-> !lsu_disp_d);

endmodule

`default_nettype wire

// ==== source/ecl_top.sv ====
`default_nettype none
`include "ecl_settings.svh"

module ecl_top (
   input  logic                    clk,
   input  logic                    reset,

   // decode stage
   input  ecl_pkg::dec_in_t        dec,
   input  logic [`ECL_GRLEN-1:0]   rs1_data_d,
   input  logic [`ECL_GRLEN-1:0]   rs2_data_d,
   output logic [`ECL_RADDR_W-1:0] rs1_addr_d,
   output logic [`ECL_RADDR_W-1:0] rs2_addr_d,

   // alu
   output ecl_pkg::alu_req_t       alu_req,
   input  logic [`ECL_GRLEN-1:0]   alu_res_e,

   // lsu
   output ecl_pkg::lsu_req_t       lsu_req,
   input  ecl_pkg::lsu_resp_t      lsu_resp,

   // bru
   output ecl_pkg::bru_req_t       bru_req,
   input  ecl_pkg::bru_resp_t      bru_resp,

   // mul
   output ecl_pkg::mul_req_t       mul_req,
   input  logic [`ECL_GRLEN-1:0]   mul_res_m,

   // fetch side
   output logic                    stall_req,
   output logic [`ECL_GRLEN-1:0]   br_pc,
   output logic                    br_taken,

   // register file write port
   output ecl_pkg::wb_t            wb
);

   import ecl_pkg::*;

   issue_e_t issue;
   wb_t      fwd_m;

   // redirect target straight from the bru
   assign br_pc = bru_resp.brpc;

   ecl_dispatch i_ecl_dispatch (
      .clk               (clk),
      .reset             (reset),
      .dec               (dec),
      .rs1_data_d        (rs1_data_d),
      .rs2_data_d        (rs2_data_d),
      .bru_taken_e       (bru_resp.taken),
      .lsu_rdata_valid_m (lsu_resp.rdata_valid),
      .rs1_addr_d        (rs1_addr_d),
      .rs2_addr_d        (rs2_addr_d),
      .issue             (issue),
      .br_taken          (br_taken),
      .stall_req         (stall_req)
   );

   ecl_issue_bypass i_ecl_issue_bypass (
      .issue   (issue),
      .fwd_m   (fwd_m),
      .wb      (wb),
      .alu_req (alu_req),
      .lsu_req (lsu_req),
      .bru_req (bru_req),
      .mul_req (mul_req)
   );

   ecl_wb_arbiter i_ecl_wb_arbiter (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .alu_res_e (alu_res_e),
      .bru_resp  (bru_resp),
      .mul_res_m (mul_res_m),
      .lsu_resp  (lsu_resp),
      .fwd_m     (fwd_m),
      .wb        (wb)
   );

endmodule

`default_nettype wire

// ==== verif/ecl_tb.sv ====
`default_nettype none
`include "ecl_settings.svh"

module ecl_tb;

   timeunit 1ns;
   timeprecision 1ns;

   import ecl_pkg::*;

   localparam int N_INST    = 400;
   localparam int MAX_CYCLE = 20 * N_INST;

   typedef logic [`ECL_GRLEN-1:0] word_t;

   // expected view of one dispatched instruction
   typedef struct packed {
      logic                       live;
      unit_e                      unit;
      logic [`ECL_ALU_CODE_W-1:0] alu_code;
      logic [`ECL_LSU_CODE_W-1:0] lsu_code;
      logic [`ECL_BRU_CODE_W-1:0] bru_code;
      mul_op_e                    mul_op;
      logic                       double_word;
      logic                       double_read;
      logic                       rf_wen;
      logic                       taken;
      logic [`ECL_RADDR_W-1:0]    target;
      logic [`ECL_RADDR_W-1:0]    rs1;
      logic [`ECL_RADDR_W-1:0]    rs2;
      word_t                      pc, a, b, c, offset, br_offs;
   } inst_exp_t;

   typedef struct packed {
      logic [31:0]             cycle;
      logic [`ECL_RADDR_W-1:0] rd;
      word_t                   data;
   } wr_exp_t;

   logic                    clk;
   logic                    reset;
   dec_in_t                 dec;
   word_t                   rs1_data_d;
   word_t                   rs2_data_d;
   logic [`ECL_RADDR_W-1:0] rs1_addr_d;
   logic [`ECL_RADDR_W-1:0] rs2_addr_d;
   alu_req_t                alu_req;
   word_t                   alu_res_e;
   lsu_req_t                lsu_req;
   lsu_resp_t               lsu_resp;
   bru_req_t                bru_req;
   bru_resp_t               bru_resp;
   mul_req_t                mul_req;
   word_t                   mul_res_m;
   logic                    stall_req;
   word_t                   br_pc;
   logic                    br_taken;
   wb_t                     wb;

   // read-port register file and the in-order reference
   word_t     rf_mem [0:31];
   word_t     ref_rf [0:31];
   wr_exp_t   wr_q [$];
   inst_exp_t d_exp;
   inst_exp_t e_exp;
   wb_t       wb_seen;
   logic      bru_wen_e;
   word_t     mul_prod;
   word_t     lsu_data;
   logic [`ECL_RADDR_W-1:0] lsu_rd;
   logic      lsu_wen;
   int        lsu_left;
   int        lsu_lat;
   int        seed;
   int        errors;
   int        checks;
   int        cycle;
   int        stall_last;
   int        n_sent;
   int        quiet_until;
   logic      timed_out;

   // alu and bru answer in the same e cycle
   assign alu_res_e = (alu_req.a ^ alu_req.b) + alu_req.c;
   assign bru_resp  = '{brpc: bru_req.pc + bru_req.offset, taken: bru_req.a == bru_req.b,
                        link_pc: bru_req.pc + 64'd4, wen: bru_wen_e};

   // write-through read so the w stage write is visible in d
   assign rs1_data_d = (wb.wen && wb.rd == rs1_addr_d) ? wb.data : rf_mem[rs1_addr_d];
   assign rs2_data_d = (wb.wen && wb.rd == rs2_addr_d) ? wb.data : rf_mem[rs2_addr_d];

   ecl_top i_ecl_top (
      .clk        (clk),
      .reset      (reset),
      .dec        (dec),
      .rs1_data_d (rs1_data_d),
      .rs2_data_d (rs2_data_d),
      .rs1_addr_d (rs1_addr_d),
      .rs2_addr_d (rs2_addr_d),
      .alu_req    (alu_req),
      .alu_res_e  (alu_res_e),
      .lsu_req    (lsu_req),
      .lsu_resp   (lsu_resp),
      .bru_req    (bru_req),
      .bru_resp   (bru_resp),
      .mul_req    (mul_req),
      .mul_res_m  (mul_res_m),
      .stall_req  (stall_req),
      .br_pc      (br_pc),
      .br_taken   (br_taken),
      .wb         (wb)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic word_t rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // signed, double, hi, short
   function automatic logic [3:0] mul_flag_table(input mul_op_e op);
      case (op)
         mul_w:    return 4'b1001;
         mulh_w:   return 4'b1011;
         mulh_wu:  return 4'b0011;
         mul_d:    return 4'b1100;
         mulh_d:   return 4'b1110;
         mulh_du:  return 4'b0110;
         mulw_d_w: return 4'b1000;
         default:  return 4'b0000;
      endcase
   endfunction

   task automatic make_inst(output dec_in_t di, output inst_exp_t ex);
      word_t                   r;
      int                      pick;
      logic [`ECL_RADDR_W-1:0] rs1;
      logic [`ECL_RADDR_W-1:0] rs2;
      di = '0;
      r = rand_word();
      pick = $unsigned($random(seed)) % 10;
      di.valid = 1'b1;
      // only registers 0 to 7 so hazards are frequent
      di.inst = $random(seed) & 32'h0000_1ce7;
      if (pick < 4) di.op.unit = unit_alu;
      else if (pick < 6) di.op.unit = unit_lsu;
      else if (pick < 8) di.op.unit = unit_bru;
      else if (pick < 9) di.op.unit = unit_mul;
      else di.op.unit = unit_none;
      di.op.alu_code    = r[5:0];
      di.op.lsu_code    = r[13:6];
      di.op.bru_code    = r[17:14];
      di.op.mul_op      = mul_op_e'(r[20:18]);
      di.op.rd_to_rj    = r[21];
      di.op.rd_read     = r[22];
      di.op.imm_b       = r[23];
      di.op.pc_a        = r[24] & r[25];
      di.op.double_read = r[26];
      di.op.double_word = r[27];
      di.rf_wen         = r[28] | r[29];
      di.rf_target      = {2'b00, r[32:30]};
      di.pc             = {32'd0, r[63:34], 2'b00};
      di.imm            = rand_word();
      di.c              = rand_word();
      di.br_offs        = rand_word();
      // now and then a branch compares rj with itself
      if (di.op.unit == unit_bru && r[33]) begin
         di.op.rd_to_rj = 1'b0;
         di.op.rd_read  = 1'b0;
         di.op.pc_a     = 1'b0;
         di.inst[`ECL_RK_LSB +: `ECL_RADDR_W] = di.inst[`ECL_RJ_LSB +: `ECL_RADDR_W];
      end
      rs1 = di.op.rd_to_rj ? di.inst[`ECL_RD_LSB +: `ECL_RADDR_W]
                           : di.inst[`ECL_RJ_LSB +: `ECL_RADDR_W];
      rs2 = di.op.rd_read ? di.inst[`ECL_RD_LSB +: `ECL_RADDR_W]
                          : di.inst[`ECL_RK_LSB +: `ECL_RADDR_W];
      ex = '0;
      ex.live        = 1'b1;
      ex.unit        = di.op.unit;
      ex.alu_code    = di.op.alu_code;
      ex.lsu_code    = di.op.lsu_code;
      ex.bru_code    = di.op.bru_code;
      ex.mul_op      = di.op.mul_op;
      ex.double_word = di.op.double_word;
      ex.double_read = di.op.double_read && di.op.unit == unit_lsu;
      ex.rf_wen      = di.rf_wen;
      ex.target      = di.rf_target;
      ex.rs1         = rs1;
      ex.rs2         = rs2;
      ex.pc          = di.pc;
      ex.c           = di.c;
      ex.br_offs     = di.br_offs;
      ex.a           = di.op.pc_a ? di.pc : ref_rf[rs1];
      ex.b           = (di.op.imm_b && di.op.unit == unit_alu) ? di.imm : ref_rf[rs2];
      ex.offset      = ex.double_read ? ref_rf[rs2] : di.imm;
      ex.taken       = di.op.unit == unit_bru && ex.a == ex.b;
   endtask

   task automatic predict_write(input inst_exp_t ex);
      word_t   res;
      int      at;
      wr_exp_t w;
      at = cycle + 3;
      case (ex.unit)
         unit_alu: res = (ex.a ^ ex.b) + ex.c;
         unit_bru: res = ex.pc + 64'd4;
         unit_mul: res = ex.a * ex.b;
         unit_lsu: begin
            lsu_lat    = 1 + ($unsigned($random(seed)) % 4);
            res        = ex.a + ex.offset;
            at         = cycle + lsu_lat + 2;
            stall_last = cycle + lsu_lat + 1;
         end
         default: res = '0;
      endcase
      if (ex.rf_wen && ex.unit != unit_none) begin
         w.cycle = at;
         w.rd    = ex.target;
         w.data  = res;
         wr_q.push_back(w);
         ref_rf[ex.target] = res;
      end
   endtask

   // new inputs on the rising edge
   task automatic drive_cycle();
      dec_in_t   di;
      inst_exp_t ex;
      logic      kill;
      if (wb_seen.wen) rf_mem[wb_seen.rd] <= wb_seen.data;
      mul_res_m <= mul_prod;
      lsu_resp.rdata_valid <= (lsu_left == 1);
      lsu_resp.rdata       <= (lsu_left == 1) ? lsu_data : rand_word();
      lsu_resp.rd          <= lsu_rd;
      lsu_resp.wen         <= lsu_wen;
      if (lsu_left > 0) lsu_left = lsu_left - 1;
      e_exp = d_exp;
      bru_wen_e <= e_exp.rf_wen;
      kill  = e_exp.live && e_exp.taken;
      d_exp = '0;
      di    = '0;
      if (cycle > 4 && n_sent < N_INST && cycle > stall_last && ($random(seed) & 3) != 0) begin
         make_inst(di, ex);
         n_sent++;
         quiet_until = cycle + 4;
         if (!kill) begin
            d_exp = ex;
            predict_write(ex);
         end
      end
      dec <= di;
   endtask

   // checks on the falling edge where outputs are settled
   task automatic check_cycle();
      logic [3:0] flags;
      logic       exp_wen;
      wr_exp_t    w;
      if (d_exp.live) begin
         check_value("rs1_addr_d", rs1_addr_d, d_exp.rs1);
         check_value("rs2_addr_d", rs2_addr_d, d_exp.rs2);
      end
      check_value("br_taken", br_taken, e_exp.live && e_exp.taken);
      check_value("stall_req", stall_req, cycle <= stall_last);
      check_value("lsu_req.valid", lsu_req.valid, e_exp.live && e_exp.unit == unit_lsu);
      check_value("bru_req.valid", bru_req.valid, e_exp.live && e_exp.unit == unit_bru);
      check_value("mul_req.valid", mul_req.valid, e_exp.live && e_exp.unit == unit_mul);
      if (e_exp.live) begin
         case (e_exp.unit)
            unit_alu: begin
               check_value("alu_req.a", alu_req.a, e_exp.a);
               check_value("alu_req.b", alu_req.b, e_exp.b);
               check_value("alu_req.c", alu_req.c, e_exp.c);
               check_value("alu_req.op", alu_req.op, e_exp.alu_code);
               check_value("alu_req.double_word", alu_req.double_word, e_exp.double_word);
            end
            unit_lsu: begin
               check_value("lsu_req.base", lsu_req.base, e_exp.a);
               check_value("lsu_req.offset", lsu_req.offset, e_exp.offset);
               check_value("lsu_req.op", lsu_req.op, e_exp.lsu_code);
               check_value("lsu_req.rd", lsu_req.rd, e_exp.target);
               check_value("lsu_req.wen", lsu_req.wen, e_exp.rf_wen);
               if (!e_exp.double_read) check_value("lsu_req.wdata", lsu_req.wdata, e_exp.b);
            end
            unit_bru: begin
               check_value("bru_req.a", bru_req.a, e_exp.a);
               check_value("bru_req.b", bru_req.b, e_exp.b);
               check_value("bru_req.pc", bru_req.pc, e_exp.pc);
               check_value("bru_req.offset", bru_req.offset, e_exp.br_offs);
               check_value("bru_req.op", bru_req.op, e_exp.bru_code);
            end
            unit_mul: begin
               flags = mul_flag_table(e_exp.mul_op);
               check_value("mul_req.a", mul_req.a, e_exp.a);
               check_value("mul_req.b", mul_req.b, e_exp.b);
               check_value("mul_req.signed_op", mul_req.signed_op, flags[3]);
               check_value("mul_req.double_op", mul_req.double_op, flags[2]);
               check_value("mul_req.hi", mul_req.hi, flags[1]);
               check_value("mul_req.short_op", mul_req.short_op, flags[0]);
            end
            default: ;
         endcase
         if (e_exp.taken) check_value("br_pc", br_pc, e_exp.pc + e_exp.br_offs);
      end
      exp_wen = wr_q.size() != 0 && wr_q[0].cycle == cycle;
      check_value("wb.wen", wb.wen, exp_wen);
      if (exp_wen) begin
         w = wr_q.pop_front();
         check_value("wb.rd", wb.rd, w.rd);
         check_value("wb.data", wb.data, w.data);
      end
      wb_seen  = wb;
      mul_prod = mul_req.a * mul_req.b;
      if (lsu_req.valid) begin
         lsu_data = lsu_req.base + lsu_req.offset;
         lsu_rd   = lsu_req.rd;
         lsu_wen  = lsu_req.wen;
         lsu_left = lsu_lat;
      end
   endtask

   initial begin
      seed        = 38;
      errors      = 0;
      checks      = 0;
      cycle       = 0;
      stall_last  = -1;
      n_sent      = 0;
      quiet_until = 0;
      lsu_left    = 0;
      lsu_lat     = 1;
      timed_out   = 1'b0;
      for (int i = 0; i < 32; i++) begin
         rf_mem[i] = 64'h0123_4567_89ab_cdef ^ (64'(i) * 64'h9e37_79b9_7f4a_7c15);
         ref_rf[i] = rf_mem[i];
      end
      reset     = 1'b1;
      dec       = '0;
      lsu_resp  = '0;
      mul_res_m = '0;
      bru_wen_e = 1'b0;
      d_exp     = '0;
      e_exp     = '0;
      wb_seen   = '0;
      mul_prod  = '0;
      lsu_data  = '0;
      lsu_rd    = '0;
      lsu_wen   = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      while (!timed_out && (n_sent < N_INST || wr_q.size() != 0 || cycle <= stall_last ||
                            cycle < quiet_until)) begin
         @(posedge clk);
         cycle++;
         drive_cycle();
         @(negedge clk);
         check_cycle();
         if (cycle >= MAX_CYCLE) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout after %0d cycles, %0d of %0d instructions sent",
                     cycle, n_sent, N_INST);
         end
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/ecl_pkg.sv
dispatch/ecl_dispatch.sv
bypass/ecl_issue_bypass.sv
writeback/ecl_wb_arbiter.sv
source/ecl_top.sv
verif/ecl_tb.sv

// ==== writeback/ecl_wb_arbiter.sv ====
`default_nettype none
`include "ecl_settings.svh"

module ecl_wb_arbiter (
   input  logic                  clk,
   input  logic                  reset,
   input  ecl_pkg::issue_e_t     issue,
   input  logic [`ECL_GRLEN-1:0] alu_res_e,
   input  ecl_pkg::bru_resp_t    bru_resp,
   input  logic [`ECL_GRLEN-1:0] mul_res_m,
   input  ecl_pkg::lsu_resp_t    lsu_resp,
   output ecl_pkg::wb_t          fwd_m,
   output ecl_pkg::wb_t          wb
);

   logic [`ECL_GRLEN-1:0]   alu_res_m;
   logic [`ECL_GRLEN-1:0]   link_pc_m;
   logic [`ECL_RADDR_W-1:0] target_m;
   logic                    alu_wen_m;
   logic                    bru_wen_m;
   logic                    mul_valid_m;
   logic                    mul_wen_m;
   logic                    lsu_claim;
   logic                    bru_claim;
   logic                    mul_claim;

   // e to m
   always_ff @(posedge clk) begin
      if (reset) begin
         alu_wen_m   <= 1'b0;
         bru_wen_m   <= 1'b0;
         mul_valid_m <= 1'b0;
         mul_wen_m   <= 1'b0;
      end else begin
         alu_wen_m   <= issue.alu_valid & issue.alu_wen;
         bru_wen_m   <= issue.bru_valid & bru_resp.wen;
         mul_valid_m <= issue.mul_valid;
         mul_wen_m   <= issue.mul_valid & issue.mul_wen;
      end
      alu_res_m <= alu_res_e;
      link_pc_m <= bru_resp.link_pc;
      target_m  <= issue.rf_target;
   end

   // peer units claim the write port, alu result is the fallback
   assign lsu_claim = lsu_resp.rdata_valid;
   assign bru_claim = bru_wen_m;
   assign mul_claim = mul_valid_m;

   always_comb begin
      if (lsu_claim) begin
         fwd_m.data = lsu_resp.rdata;
      end else if (bru_claim) begin
         fwd_m.data = link_pc_m;
      end else if (mul_claim) begin
         fwd_m.data = mul_res_m;
      end else begin
         fwd_m.data = alu_res_m;
      end
      // a returning load may carry no write
      fwd_m.wen = alu_wen_m | (lsu_claim & lsu_resp.wen) | bru_claim | mul_wen_m;
      fwd_m.rd  = lsu_claim ? lsu_resp.rd : target_m;
   end

   // m to w, single register file write port
   always_ff @(posedge clk) begin
      if (reset) begin
         wb.wen <= 1'b0;
      end else begin
         wb.wen <= fwd_m.wen;
      end
      wb.data <= fwd_m.data;
      wb.rd   <= fwd_m.rd;
   end

   // load stall keeps the peers apart in m
   a_one_peer_claim: assert property (
      @(posedge clk) disable iff (reset) $onehot0({lsu_claim, bru_claim, mul_claim}));

endmodule

`default_nettype wire
